// File: files.f
+incdir+design
design/spi_pkg.sv
design/adc_pkg.sv
design/adc_reset_timer.sv
design/spi_word_engine.sv
design/adc_sequencer.sv
design/adc_spi_master.sv
verif/tb_adc_spi_master.sv

// File: Makefile
# Verilator flow for the ADC SPI master

TOP := tb_adc_spi_master

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// File: verif/tb_adc_spi_master.sv
/*
 * Testbench for the ADC SPI master with a behavioral ADC on the SPI pins.
 * The ADC model knows the init command order, so it can answer each init
 * word during the same frame. One init reply is corrupted to force a retry.
 * DRDY edges are only dropped when the DUT is clearly idle or clearly
 * inside a frame, never in the last word of a frame.
 */

`timescale 1ns/1ns
`include "adc_defs.svh"

module tb_adc_spi_master;

	import spi_pkg::*;
	import adc_pkg::*;

	localparam int INIT_WORDS  = `ADC_NUM_INIT_CMDS + 1;   // One retry
	localparam int FRAME_WORDS = `ADC_FRAME_WORDS;
	localparam int NUM_FRAMES  = 6;
	localparam int NUM_GAPS    = 24;
	localparam int DRDY_LOW    = 20;

	localparam int RESET_BUDGET   = `ADC_RESET_LOW_CYCLES + `ADC_RESET_SETTLE_CYCLES + 10;
	localparam int INIT_BUDGET    = INIT_WORDS * 68;
	localparam int FRAME_BUDGET   = NUM_FRAMES * (300 + FRAME_WORDS * 68);
	localparam int TIMEOUT_CYCLES = (RESET_BUDGET + INIT_BUDGET + FRAME_BUDGET) * 3 / 2;

	// Power-up register writes and the ADC answers to them
	localparam spi_word_t CMD_WORDS [`ADC_NUM_INIT_CMDS] = '{
		32'h0000_0000, 32'h0655_0000, 32'h4B68_0000, 32'h4C3E_0000, 32'h4D02_0000,
		32'h4E25_0000, 32'h4F0F_0000, 32'h0033_0000, 32'h0555_0000
	};
	localparam spi_word_t REPLY_WORDS [`ADC_NUM_INIT_CMDS] = '{
		32'hFF04_0000, 32'h0655_0000, 32'h2B68_0000, 32'h2C3E_0000, 32'h2D02_0000,
		32'h2E25_0000, 32'h2F0F_0000, 32'h0033_0000, 32'h0555_0000
	};

	logic        synthesized_clock_8_333Mhz;
	logic        reset_n = 1'b0;
	logic        spi_miso_i = 1'b0;
	logic        spi_drdy_i = 1'b1;
	logic        spi_sclk_o;
	logic        spi_mosi_o;
	logic        spi_cs_n_o;
	logic        spi_reset_n_o;
	logic        init_done_o;
	adc_sample_t sample_o;
	logic        sample_valid_o;

	integer    seed = 32'h6de9;
	int        gaps [NUM_GAPS];
	spi_word_t reply_words [NUM_FRAMES * FRAME_WORDS];
	int        bad_idx;              // Init command whose first reply is corrupted
	spi_word_t corrupt_mask;
	spi_word_t exp_samples [$];

	logic      cs_prev_q = 1'b1;
	spi_word_t miso_sh_q = '0;
	spi_word_t mosi_sh_q = '0;
	int        word_cnt_q = 0;
	int        acq_words_q = 0;       // Words done in the running frame
	int        acq_total_q = 0;
	int        frames_q = 0;
	int        frames_done_q = 0;
	int        edges_accepted = 0;
	int        edges_ignored = 0;
	int        sample_cnt = 0;
	int        reset_low_cnt = 0;
	int        settle_cnt = 0;
	int        cycle_cnt = 0;

	adc_spi_master dut (
		.synthesized_clock_8_333Mhz (synthesized_clock_8_333Mhz),
		.reset_n                    (reset_n),
		.spi_sclk_o                 (spi_sclk_o),
		.spi_mosi_o                 (spi_mosi_o),
		.spi_cs_n_o                 (spi_cs_n_o),
		.spi_reset_n_o              (spi_reset_n_o),
		.spi_miso_i                 (spi_miso_i),
		.spi_drdy_i                 (spi_drdy_i),
		.init_done_o                (init_done_o),
		.sample_o                   (sample_o),
		.sample_valid_o             (sample_valid_o)
	);

	initial begin
		synthesized_clock_8_333Mhz = 1'b0;
		forever #5 synthesized_clock_8_333Mhz = ~synthesized_clock_8_333Mhz;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual)
			abort_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
	endtask

	// Table position of the n-th init word, the corrupted command repeats
	function automatic int init_cmd_pos(input int word_pos);
		return (word_pos <= bad_idx) ? word_pos : word_pos - 1;
	endfunction

	// Idle with no frame pending, or a frame with at least one full word left
	function automatic logic drop_is_safe();
		logic idle;
		logic mid;
		idle = (frames_done_q == edges_accepted);
		mid  = (frames_q == edges_accepted) && (frames_done_q < frames_q) &&
			(acq_words_q < FRAME_WORDS - 1);
		return idle || mid;
	endfunction

	// --------------------
	// ADC model
	// --------------------
	always @(posedge synthesized_clock_8_333Mhz) begin : adc_model
		spi_word_t reply;
		if (!reset_n) begin
			cs_prev_q  <= 1'b1;
			spi_miso_i <= 1'b0;
		end else begin
			cs_prev_q <= spi_cs_n_o;
			if (!spi_cs_n_o && cs_prev_q) begin          // CS just fell
				if (word_cnt_q < INIT_WORDS) begin
					check_value("init_done_during_init", 0, 32'(init_done_o));
					reply = REPLY_WORDS[init_cmd_pos(word_cnt_q)];
					if (word_cnt_q == bad_idx)
						reply = reply ^ corrupt_mask;
					if (word_cnt_q == 0) begin
						check_value("adc_reset_low_cycles", `ADC_RESET_LOW_CYCLES,
							reset_low_cnt);
						check_value("adc_settle_interval", 1,
							32'(settle_cnt >= `ADC_RESET_SETTLE_CYCLES));
					end
				end else begin
					if (acq_words_q == 0) begin
						check_value("frame_without_drdy_edge", edges_accepted, frames_q + 1);
						frames_q <= frames_q + 1;
					end
					reply = reply_words[acq_total_q];
					exp_samples.push_back(reply);
					acq_total_q <= acq_total_q + 1;
				end
				word_cnt_q <= word_cnt_q + 1;
				spi_miso_i <= reply[`ADC_WORD_W-1];
				miso_sh_q  <= reply << 1;
			end else if (!spi_cs_n_o && spi_sclk_o) begin   // Just after rising SCLK
				mosi_sh_q  <= {mosi_sh_q[`ADC_WORD_W-2:0], spi_mosi_o};
				spi_miso_i <= miso_sh_q[`ADC_WORD_W-1];
				miso_sh_q  <= miso_sh_q << 1;
			end else if (spi_cs_n_o && !cs_prev_q) begin    // Word finished
				if (word_cnt_q <= INIT_WORDS) begin
					check_value("init_cmd_order", CMD_WORDS[init_cmd_pos(word_cnt_q - 1)],
						mosi_sh_q);
				end else begin
					check_value("frame_mosi_zero", 0, mosi_sh_q);
					if (acq_words_q == FRAME_WORDS - 1) begin
						acq_words_q   <= 0;
						frames_done_q <= frames_done_q + 1;
					end else begin
						acq_words_q <= acq_words_q + 1;
					end
				end
			end
		end
	end

	// --------------------
	// Monitors
	// --------------------
	always @(posedge synthesized_clock_8_333Mhz) begin : reset_pin_monitor
		if (reset_n) begin
			if (!spi_reset_n_o) begin
				if (settle_cnt != 0)
					abort_run("ADC reset pin went low again after its release");
				else
					reset_low_cnt <= reset_low_cnt + 1;
				check_value("cs_during_adc_reset", 1, 32'(spi_cs_n_o));
			end else if (reset_low_cnt != 0) begin
				settle_cnt <= settle_cnt + 1;
			end
		end
	end

	always @(posedge synthesized_clock_8_333Mhz) begin : sample_checker
		spi_word_t expected;
		if (reset_n && sample_valid_o) begin
			check_value("sample_before_init_done", 1, 32'(init_done_o));
			if (exp_samples.size() == 0) begin
				abort_run("A sample arrived while no ADC word was pending");
			end else begin
				expected = exp_samples.pop_front();
				check_value("sample_index", sample_cnt % FRAME_WORDS, 32'(sample_o.idx));
				check_value("sample_word", expected, sample_o.word);
				sample_cnt <= sample_cnt + 1;
			end
		end
	end

	always @(posedge synthesized_clock_8_333Mhz) begin : watchdog
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			abort_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_cnt));
	end

	// --------------------
	// Stimulus
	// --------------------
	initial begin : main
		int i;
		int gap_pos;
		for (i = 0; i < NUM_GAPS; i++)
			gaps[i] = 100 + int'($unsigned($random(seed)) % 201);
		for (i = 0; i < NUM_FRAMES * FRAME_WORDS; i++)
			reply_words[i] = $random(seed);
		bad_idx      = int'($unsigned($random(seed)) % `ADC_NUM_INIT_CMDS);
		corrupt_mask = $random(seed) | 32'h1;    // Never zero

		repeat (2) @(posedge synthesized_clock_8_333Mhz);
		reset_n <= 1'b1;

		while (!init_done_o)
			@(posedge synthesized_clock_8_333Mhz);
		check_value("init_word_count", INIT_WORDS, word_cnt_q);

		gap_pos = 0;
		while (edges_accepted < NUM_FRAMES) begin
			repeat (gaps[gap_pos % NUM_GAPS]) @(posedge synthesized_clock_8_333Mhz);
			gap_pos = gap_pos + 1;
			while (!drop_is_safe())
				@(posedge synthesized_clock_8_333Mhz);
			if (frames_done_q == edges_accepted)
				edges_accepted <= edges_accepted + 1;
			else
				edges_ignored <= edges_ignored + 1;   // Lands inside a frame
			spi_drdy_i <= 1'b0;
			repeat (DRDY_LOW) @(posedge synthesized_clock_8_333Mhz);
			spi_drdy_i <= 1'b1;
		end

		while (frames_done_q < NUM_FRAMES)
			@(posedge synthesized_clock_8_333Mhz);
		repeat (50) @(posedge synthesized_clock_8_333Mhz);   // Room for a stray frame

		check_value("ignored_edges_seen", 1, 32'(edges_ignored > 0));
		check_value("sample_count", NUM_FRAMES * FRAME_WORDS, sample_cnt);
		$display("Verification passed");
		$finish;
	end

endmodule

// File: design/adc_spi_master.sv
/*
 * SPI master for a four channel delta-sigma ADC.
 * Pulses the ADC reset pin, writes the init table, then reads one
 * status word and four channel words per DRDY falling edge.
 * Samples are one-cycle pulses with no back-pressure.
 */

`timescale 1ns/1ns

module adc_spi_master (
	input  logic                 synthesized_clock_8_333Mhz,
	input  logic                 reset_n,
	output logic                 spi_sclk_o,
	output logic                 spi_mosi_o,
	output logic                 spi_cs_n_o,
	output logic                 spi_reset_n_o,
	input  logic                 spi_miso_i,
	input  logic                 spi_drdy_i,
	output logic                 init_done_o,
	output adc_pkg::adc_sample_t sample_o,
	output logic                 sample_valid_o
);

	import spi_pkg::*;

	logic      adc_ready;
	logic      word_start;
	logic      word_done;
	spi_word_t tx_word;
	spi_word_t rx_word;

	adc_reset_timer u_reset_timer (
		.synthesized_clock_8_333Mhz (synthesized_clock_8_333Mhz),
		.reset_n                    (reset_n),
		.spi_reset_n_o              (spi_reset_n_o),
		.adc_ready_o                (adc_ready)
	);

	spi_word_engine u_word_engine (
		.synthesized_clock_8_333Mhz (synthesized_clock_8_333Mhz),
		.reset_n                    (reset_n),
		.word_start_i               (word_start),
		.tx_word_i                  (tx_word),
		.spi_miso_i                 (spi_miso_i),
		.spi_sclk_o                 (spi_sclk_o),
		.spi_mosi_o                 (spi_mosi_o),
		.spi_cs_n_o                 (spi_cs_n_o),
		.word_done_o                (word_done),
		.rx_word_o                  (rx_word)
	);

	adc_sequencer u_sequencer (
		.synthesized_clock_8_333Mhz (synthesized_clock_8_333Mhz),
		.reset_n                    (reset_n),
		.adc_ready_i                (adc_ready),
		.spi_drdy_i                 (spi_drdy_i),
		.word_done_i                (word_done),
		.rx_word_i                  (rx_word),
		.word_start_o               (word_start),
		.tx_word_o                  (tx_word),
		.init_done_o                (init_done_o),
		.sample_o                   (sample_o),
		.sample_valid_o             (sample_valid_o)
	);

endmodule

// File: design/adc_sequencer.sv
/*
 * Runs the ADC init command table, then one frame per DRDY falling edge.
 * A command whose reply does not match is sent again, with no retry limit.
 * DRDY is only watched after init; edges during a frame are ignored.
 * sample_o is valid only in the cycle sample_valid_o is high.
 */

`timescale 1ns/1ns
`include "adc_defs.svh"

module adc_sequencer (
	input  logic                 synthesized_clock_8_333Mhz,
	input  logic                 reset_n,
	input  logic                 adc_ready_i,
	input  logic                 spi_drdy_i,
	input  logic                 word_done_i,
	input  spi_pkg::spi_word_t   rx_word_i,
	output logic                 word_start_o,
	output spi_pkg::spi_word_t   tx_word_o,
	output logic                 init_done_o,
	output adc_pkg::adc_sample_t sample_o,
	output logic                 sample_valid_o
);

	import spi_pkg::*;
	import adc_pkg::*;

	localparam adc_cmd_idx_t  LAST_CMD  = `ADC_CMD_IDX_W'(`ADC_NUM_INIT_CMDS - 1);
	localparam adc_word_idx_t LAST_WORD = `ADC_WORD_IDX_W'(`ADC_FRAME_WORDS - 1);

	adc_seq_state_t state_q;
	adc_cmd_idx_t   cmd_idx_q;
	adc_word_idx_t  word_idx_q;
	logic           start_q;
	logic           init_done_q;
	logic [2:0]     drdy_sync_q;   // [0] meta, [1] synced, [2] previous

	logic drdy_fall;

	assign drdy_fall = drdy_sync_q[2] && !drdy_sync_q[1];

	always_ff @(posedge synthesized_clock_8_333Mhz) begin
		if (!reset_n) begin
			state_q     <= WAIT_RESET;
			cmd_idx_q   <= '0;
			word_idx_q  <= '0;
			start_q     <= 1'b0;
			init_done_q <= 1'b0;
			drdy_sync_q <= 3'b111;   // Idle high, no false edge
		end else begin
			start_q <= 1'b0;

			if (init_done_q)
				drdy_sync_q <= {drdy_sync_q[1:0], spi_drdy_i};

			unique case (state_q)
				WAIT_RESET: begin
					if (adc_ready_i) begin
						cmd_idx_q <= '0;
						start_q   <= 1'b1;
						state_q   <= INIT_SEND;
					end
				end
				INIT_SEND: begin
					if (word_done_i)
						state_q <= INIT_CHECK;
				end
				// Engine is idle here so rx_word_i still holds the reply
				INIT_CHECK: begin
					if (rx_word_i != ADC_INIT_TABLE[cmd_idx_q].reply) begin
						start_q <= 1'b1;   // Same command again
						state_q <= INIT_SEND;
					end else if (cmd_idx_q == LAST_CMD) begin
						init_done_q <= 1'b1;
						state_q     <= WAIT_DRDY;
					end else begin
						cmd_idx_q <= cmd_idx_q + 1'b1;
						start_q   <= 1'b1;
						state_q   <= INIT_SEND;
					end
				end
				// --------------------
				// Acquisition
				// --------------------
				WAIT_DRDY: begin
					if (drdy_fall) begin
						word_idx_q <= '0;
						start_q    <= 1'b1;
						state_q    <= FRAME_SEND;
					end
				end
				FRAME_SEND: begin
					if (word_done_i) begin
						if (word_idx_q == LAST_WORD) begin
							state_q <= WAIT_DRDY;
						end else begin
							word_idx_q <= word_idx_q + 1'b1;
							state_q    <= FRAME_NEXT;
						end
					end
				end
				FRAME_NEXT: begin
					start_q <= 1'b1;
					state_q <= FRAME_SEND;
				end
				default: state_q <= WAIT_RESET;
			endcase
		end
	end

	// Zero words during frames, table command during init
	assign tx_word_o    = init_done_q ? '0 : ADC_INIT_TABLE[cmd_idx_q].cmd;
	assign word_start_o = start_q;
	assign init_done_o  = init_done_q;

	assign sample_o.idx   = word_idx_q;
	assign sample_o.word  = rx_word_i;
	assign sample_valid_o = (state_q == FRAME_SEND) && word_done_i;

	// No new start until the engine has returned the previous word
	a_start_only_when_idle: assert property (
		@(posedge synthesized_clock_8_333Mhz) disable iff (!reset_n)
		word_start_o |=> (!word_start_o throughout word_done_i[->1])
	) else $error("word_start issued while SPI engine busy");

endmodule

// File: design/spi_word_engine.sv
/*
 * Transfers one 32-bit word per start pulse, SPI mode CPOL 0, CPHA 1.
 * SCLK runs at half the clock rate, so a word takes 64 clock cycles;
 * from the start pulse to word_done_o is 66 cycles.
 * Starts that arrive while a word is in progress are dropped.
 */

`timescale 1ns/1ns
`include "adc_defs.svh"

module spi_word_engine (
	input  logic               synthesized_clock_8_333Mhz,
	input  logic               reset_n,
	input  logic               word_start_i,
	input  spi_pkg::spi_word_t tx_word_i,
	input  logic               spi_miso_i,
	output logic               spi_sclk_o,
	output logic               spi_mosi_o,
	output logic               spi_cs_n_o,
	output logic               word_done_o,
	output spi_pkg::spi_word_t rx_word_o
);

	import spi_pkg::*;

	localparam spi_bit_idx_t LAST_BIT = `ADC_BIT_IDX_W'(`ADC_WORD_W);

	logic         busy_q;
	logic         sclk_q;
	logic         cs_n_q;
	logic         mosi_q;
	logic         done_q;
	spi_bit_idx_t bit_cnt_q;   // Completed bits
	spi_word_t    tx_sh_q;
	spi_word_t    rx_sh_q;

	logic accept;
	logic sclk_rise;
	logic sclk_fall;

	assign accept    = !busy_q && word_start_i;
	assign sclk_rise = busy_q && !sclk_q && (bit_cnt_q != LAST_BIT);
	assign sclk_fall = busy_q && sclk_q;

	// --------------------
	// Control and SCLK
	// --------------------
	always_ff @(posedge synthesized_clock_8_333Mhz) begin
		if (!reset_n) begin
			busy_q    <= 1'b0;
			sclk_q    <= 1'b0;
			cs_n_q    <= 1'b1;
			mosi_q    <= 1'b0;
			done_q    <= 1'b0;
			bit_cnt_q <= '0;
		end else begin
			done_q <= 1'b0;
			if (accept) begin
				busy_q    <= 1'b1;
				cs_n_q    <= 1'b0;   // One cycle of CS setup before first edge
				bit_cnt_q <= '0;
			end else if (sclk_rise) begin
				sclk_q <= 1'b1;
				mosi_q <= tx_sh_q[`ADC_WORD_W-1];   // MSB first, ADC samples on fall
			end else if (sclk_fall) begin
				sclk_q    <= 1'b0;
				bit_cnt_q <= bit_cnt_q + 1'b1;
			end else if (busy_q) begin
				// All bits done and SCLK back low
				busy_q <= 1'b0;
				cs_n_q <= 1'b1;
				mosi_q <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end

	// --------------------
	// Shift registers
	// --------------------
	always_ff @(posedge synthesized_clock_8_333Mhz) begin
		if (accept)
			tx_sh_q <= tx_word_i;
		else if (sclk_rise)
			tx_sh_q <= tx_sh_q << 1;

		if (sclk_fall)
			rx_sh_q <= {rx_sh_q[`ADC_WORD_W-2:0], spi_miso_i};
	end

	assign spi_sclk_o  = sclk_q;
	assign spi_cs_n_o  = cs_n_q;
	assign spi_mosi_o  = mosi_q;
	assign word_done_o = done_q;
	assign rx_word_o   = rx_sh_q;   // Stable until the next word starts

	a_cs_high_when_idle: assert property (
		@(posedge synthesized_clock_8_333Mhz) disable iff (!reset_n)
		!busy_q |-> spi_cs_n_o
	) else $error("CS asserted while SPI engine idle");

	a_sclk_low_without_cs: assert property (
		@(posedge synthesized_clock_8_333Mhz) disable iff (!reset_n)
		spi_cs_n_o |-> !spi_sclk_o
	) else $error("SCLK toggled with CS deasserted");

endmodule

// File: design/adc_reset_timer.sv
/*
 * ADC hardware reset pulse after system reset.
 * The pin is low for ADC_RESET_LOW_CYCLES, then adc_ready_o rises
 * ADC_RESET_SETTLE_CYCLES later and stays high until the next reset.
 */

`timescale 1ns/1ns
`include "adc_defs.svh"

module adc_reset_timer (
	input  logic synthesized_clock_8_333Mhz,
	input  logic reset_n,
	output logic spi_reset_n_o,
	output logic adc_ready_o
);

	localparam int unsigned TOTAL_CYCLES = `ADC_RESET_LOW_CYCLES + `ADC_RESET_SETTLE_CYCLES;
	localparam int unsigned CNT_W        = $clog2(TOTAL_CYCLES + 1);

	localparam logic [CNT_W-1:0] LOW_END   = CNT_W'(`ADC_RESET_LOW_CYCLES);
	localparam logic [CNT_W-1:0] SETTLE_END = CNT_W'(TOTAL_CYCLES);

	logic [CNT_W-1:0] cnt_q;

	// Single counter covers the low phase and then the settle phase
	always_ff @(posedge synthesized_clock_8_333Mhz) begin
		if (!reset_n) begin
			cnt_q         <= '0;
			spi_reset_n_o <= 1'b1;
			adc_ready_o   <= 1'b0;
		end else if (!adc_ready_o) begin
			cnt_q         <= cnt_q + 1'b1;
			spi_reset_n_o <= (cnt_q >= LOW_END);   // Low from the first cycle
			if (cnt_q == SETTLE_END)
				adc_ready_o <= 1'b1;
		end
	end

	// Ready must only appear once the ADC is out of reset
	a_ready_after_release: assert property (
		@(posedge synthesized_clock_8_333Mhz) disable iff (!reset_n)
		$rose(adc_ready_o) |-> spi_reset_n_o && $past(spi_reset_n_o)
	) else $error("adc_ready rose while ADC reset pin was low");

endmodule

// File: design/adc_pkg.sv
/*
 * ADC specific types: init command table, sequencer states and samples.
 * The table holds the power-up register writes in the order they are sent.
 * The expected reply of the first command is the status after ADC reset.
 */

`include "adc_defs.svh"

package adc_pkg;

	typedef logic [`ADC_CMD_IDX_W-1:0]  adc_cmd_idx_t;
	typedef logic [`ADC_WORD_IDX_W-1:0] adc_word_idx_t;   // 0 is status

	// Command word and the word the ADC must return for it
	typedef struct packed {
		spi_pkg::spi_word_t cmd;
		spi_pkg::spi_word_t reply;
	} adc_cmd_entry_t;

	// --------------------
	// Init sequence
	// --------------------
	parameter adc_cmd_entry_t ADC_INIT_TABLE [`ADC_NUM_INIT_CMDS] = '{
		'{cmd: 32'h0000_0000, reply: 32'hFF04_0000},   // Null, reset status
		'{cmd: 32'h0655_0000, reply: 32'h0655_0000},   // Unlock
		'{cmd: 32'h4B68_0000, reply: 32'h2B68_0000},
		'{cmd: 32'h4C3E_0000, reply: 32'h2C3E_0000},
		'{cmd: 32'h4D02_0000, reply: 32'h2D02_0000},
		'{cmd: 32'h4E25_0000, reply: 32'h2E25_0000},
		'{cmd: 32'h4F0F_0000, reply: 32'h2F0F_0000},
		'{cmd: 32'h0033_0000, reply: 32'h0033_0000},   // Wakeup
		'{cmd: 32'h0555_0000, reply: 32'h0555_0000}    // Lock
	};

	typedef enum logic [2:0] {
		WAIT_RESET,
		INIT_SEND,
		INIT_CHECK,
		WAIT_DRDY,
		FRAME_SEND,
		FRAME_NEXT
	} adc_seq_state_t;

	// One word of an acquisition frame, tagged with its position
	typedef struct packed {
		adc_word_idx_t      idx;
		spi_pkg::spi_word_t word;
	} adc_sample_t;

endpackage

// File: design/spi_pkg.sv
/*
 * Types for a single SPI word transfer.
 * Words go out MSB first; the bit index counts up to the full word width.
 */

`include "adc_defs.svh"

package spi_pkg;

	// One word as it appears on MOSI or MISO
	typedef logic [`ADC_WORD_W-1:0] spi_word_t;

	// Bit position within a word, 0 up to ADC_WORD_W inclusive
	typedef logic [`ADC_BIT_IDX_W-1:0] spi_bit_idx_t;

endpackage

// File: design/adc_defs.svh
/*
 * Shared sizes and timing for the ADC SPI master.
 * Reset interval counts are in cycles of the 8.333 MHz clock. The defaults
 * are kept small for simulation; on hardware use 41665 and 166660.
 * The frame length always follows the channel count (one status word first).
 */

`ifndef ADC_DEFS_SVH
`define ADC_DEFS_SVH

// --------------------
// SPI word format
// --------------------
`define ADC_WORD_W               32
`define ADC_BIT_IDX_W            6    // Must hold ADC_WORD_W itself

// --------------------
// Reset pulse timing
// --------------------
`define ADC_RESET_LOW_CYCLES     40   // Hardware value 41665
`define ADC_RESET_SETTLE_CYCLES  60   // Hardware value 166660

// --------------------
// Command table and frames
// --------------------
`define ADC_NUM_INIT_CMDS        9
`define ADC_CMD_IDX_W            4
`define ADC_NUM_CHANNELS         4
`define ADC_FRAME_WORDS          (1 + `ADC_NUM_CHANNELS)
`define ADC_WORD_IDX_W           3    // Word index within a frame

`endif
